// File: common/exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// ------------------------------------------------------------------------
// execute stage widths
// ------------------------------------------------------------------------

`define EXE_XLEN    32      // data path width
`define EXE_RNUM_W  5       // register number
`define EXE_BE_W    4       // one enable per byte lane

// ------------------------------------------------------------------------
// reset values
// ------------------------------------------------------------------------

`define EXE_VALID_RST  1'b0     // stage empty after reset

`endif

// File: common/exe_pkg.sv
`include "exe_defs.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]   word_t;
    typedef logic [`EXE_RNUM_W-1:0] rnum_t;
    typedef logic [`EXE_BE_W-1:0]   be_t;

    // ------------------------------------------------------------------------
    // operation encodings
    // ------------------------------------------------------------------------

    typedef enum logic [3:0] {
        alu_add, alu_addu, alu_sub, alu_subu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_lwl, mem_lwr,
        mem_sb, mem_sh, mem_sw, mem_swl, mem_swr
    } mem_op_t;

    // cp0 cause codes
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,    // load address error
        exc_ades = 5'd5,    // store address error
        exc_ov   = 5'd12    // signed overflow
    } exc_code_t;

endpackage

// File: common/store_if.sv
`timescale 1ns/1ps

// store operand out to the formatter, lane data and enables back
interface store_if;

    exe_pkg::word_t   store_data;   // register operand
    exe_pkg::mem_op_t mem_op;
    logic [1:0]       addr_lo;      // byte offset in word
    exe_pkg::word_t   dm_data;
    exe_pkg::be_t     dm_we;

    modport stage (
        output store_data,
        output mem_op,
        output addr_lo,
        input  dm_data,
        input  dm_we
    );

    modport formatter (
        input  store_data,
        input  mem_op,
        input  addr_lo,
        output dm_data,
        output dm_we
    );

endinterface

// File: exe/alu.sv
`timescale 1ns/1ps

module alu (
    input  exe_pkg::alu_op_t op,
    input  exe_pkg::word_t   a,
    input  exe_pkg::word_t   b,
    output exe_pkg::word_t   res,
    output logic             overflow
);

    exe_pkg::word_t sum;
    exe_pkg::word_t diff;
    logic [4:0]     shamt;
    logic           add_ov;
    logic           sub_ov;

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = a[4:0];      // shift amount comes from operand a

    // operands of equal sign, result sign flipped
    assign add_ov = (a[31] == b[31]) && (sum[31] != a[31]);
    // operands of opposite sign, result takes sign of b
    assign sub_ov = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        res = '0;
        case (op)
            exe_pkg::alu_add,
            exe_pkg::alu_addu: res = sum;
            exe_pkg::alu_sub,
            exe_pkg::alu_subu: res = diff;
            exe_pkg::alu_and:  res = a & b;
            exe_pkg::alu_or:   res = a | b;
            exe_pkg::alu_xor:  res = a ^ b;
            exe_pkg::alu_nor:  res = ~(a | b);
            exe_pkg::alu_slt:  res = {31'b0, $signed(a) < $signed(b)};
            exe_pkg::alu_sltu: res = {31'b0, a < b};
            exe_pkg::alu_sll:  res = b << shamt;
            exe_pkg::alu_srl:  res = b >> shamt;
            exe_pkg::alu_sra:  res = $signed(b) >>> shamt;
            exe_pkg::alu_lui:  res = {b[15:0], 16'h0000};
            default:           res = '0;
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        case (op)
            exe_pkg::alu_add: overflow = add_ov;
            exe_pkg::alu_sub: overflow = sub_ov;
            default:          overflow = 1'b0;
        endcase
    end

endmodule

// File: exe/store_align.sv
`timescale 1ns/1ps

module store_align (
    store_if.formatter st
);

    logic [3:0] off_oh;     // one-hot byte offset
    logic [3:0] left_we;
    logic [3:0] right_we;
    logic [4:0] left_sh;
    logic [4:0] right_sh;

    assign off_oh = 4'b0001 << st.addr_lo;

    // ------------------------------------------------------------------------
    // unaligned lane masks
    // ------------------------------------------------------------------------

    // swl covers lanes 0 up to the offset
    assign left_we[0] = 1'b1;
    assign left_we[1] = |off_oh[3:1];
    assign left_we[2] = |off_oh[3:2];
    assign left_we[3] = off_oh[3];

    // swr covers the offset up to lane 3
    assign right_we[0] = off_oh[0];
    assign right_we[1] = |off_oh[1:0];
    assign right_we[2] = |off_oh[2:0];
    assign right_we[3] = 1'b1;

    assign left_sh  = {~st.addr_lo, 3'b000};   // 8*(3-k)
    assign right_sh = {st.addr_lo, 3'b000};    // 8*k

    // ------------------------------------------------------------------------
    // data and enables per store form
    // ------------------------------------------------------------------------

    always_comb begin
        st.dm_data = st.store_data;
        st.dm_we   = '0;
        case (st.mem_op)
            exe_pkg::mem_sb: begin
                st.dm_data = {4{st.store_data[7:0]}};
                st.dm_we   = off_oh;
            end
            exe_pkg::mem_sh: begin
                st.dm_data = {2{st.store_data[15:0]}};
                st.dm_we   = st.addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            exe_pkg::mem_sw: begin
                st.dm_we = 4'b1111;
            end
            exe_pkg::mem_swl: begin
                st.dm_data = st.store_data >> left_sh;
                st.dm_we   = left_we;
            end
            exe_pkg::mem_swr: begin
                st.dm_data = st.store_data << right_sh;
                st.dm_we   = right_we;
            end
            default: st.dm_we = '0;     // loads and plain alu ops
        endcase
    end

endmodule

// File: exe/addr_exc.sv
`timescale 1ns/1ps

module addr_exc (
    input  exe_pkg::mem_op_t   mem_op,
    input  logic [1:0]         addr_lo,
    input  logic               overflow,
    output exe_pkg::exc_code_t code
);

    always_comb begin
        code = exe_pkg::exc_none;
        if (overflow) begin
            code = exe_pkg::exc_ov;     // wins over address faults
        end else begin
            case (mem_op)
                exe_pkg::mem_lh,
                exe_pkg::mem_lhu: if (addr_lo[0]) code = exe_pkg::exc_adel;
                exe_pkg::mem_lw:  if (|addr_lo)   code = exe_pkg::exc_adel;
                exe_pkg::mem_sh:  if (addr_lo[0]) code = exe_pkg::exc_ades;
                exe_pkg::mem_sw:  if (|addr_lo)   code = exe_pkg::exc_ades;
                // byte and left/right forms are always aligned
                default: code = exe_pkg::exc_none;
            endcase
        end
    end

endmodule

// File: exe/exe_stage.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_stage (
    input  logic                clk,
    input  logic                rst_n,
    // decode side
    input  logic                id_valid,
    output logic                allowin,
    input  exe_pkg::alu_op_t    alu_op,
    input  exe_pkg::word_t      src_a,
    input  exe_pkg::word_t      src_b,
    input  exe_pkg::mem_op_t    mem_op,
    input  exe_pkg::word_t      store_data,
    input  exe_pkg::rnum_t      wnum,
    input  logic                wen,
    input  exe_pkg::word_t      pc,
    // memory side
    input  logic                mem_allowin,
    output logic                out_valid,
    output exe_pkg::word_t      alu_res,
    output exe_pkg::word_t      dm_addr,
    output exe_pkg::word_t      dm_data,
    output exe_pkg::be_t        dm_we,
    output exe_pkg::mem_op_t    mem_op_out,
    output exe_pkg::rnum_t      wnum_out,
    output logic                wen_out,
    output exe_pkg::exc_code_t  exc_code,
    output exe_pkg::word_t      pc_out,
    // store formatter
    store_if.stage              st,
    store_if.formatter          fmt
);

    logic               valid_r;
    exe_pkg::alu_op_t   alu_op_r;
    exe_pkg::word_t     src_a_r;
    exe_pkg::word_t     src_b_r;
    exe_pkg::mem_op_t   mem_op_r;
    exe_pkg::word_t     store_data_r;
    exe_pkg::rnum_t     wnum_r;
    logic               wen_r;
    exe_pkg::word_t     pc_r;

    exe_pkg::word_t     res;
    logic               overflow;
    exe_pkg::exc_code_t code;
    logic               commit_ok;     // valid and no exception

    // ------------------------------------------------------------------------
    // handshake and pipeline register
    // ------------------------------------------------------------------------

    assign allowin   = !valid_r || mem_allowin;   // always ready, no mul/div
    assign out_valid = valid_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= `EXE_VALID_RST;
        end else if (allowin) begin
            valid_r <= id_valid;    // empties when nothing new arrives
        end
    end

    always_ff @(posedge clk) begin
        if (allowin && id_valid) begin
            alu_op_r     <= alu_op;
            src_a_r      <= src_a;
            src_b_r      <= src_b;
            mem_op_r     <= mem_op;
            store_data_r <= store_data;
            wnum_r       <= wnum;
            wen_r        <= wen;
            pc_r         <= pc;
        end
    end

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------

    alu u_alu (
        .op       (alu_op_r),
        .a        (src_a_r),
        .b        (src_b_r),
        .res      (res),
        .overflow (overflow)
    );

    assign st.store_data = store_data_r;
    assign st.mem_op     = mem_op_r;
    assign st.addr_lo    = res[1:0];

    store_align u_store_align (
        .st (fmt)
    );

    addr_exc u_addr_exc (
        .mem_op   (mem_op_r),
        .addr_lo  (res[1:0]),
        .overflow (overflow),
        .code     (code)
    );

    // faulting or empty slot must not write anything
    assign commit_ok = valid_r && (code == exe_pkg::exc_none);

    assign alu_res    = res;
    assign dm_addr    = res;
    assign dm_data    = st.dm_data;
    assign dm_we      = commit_ok ? st.dm_we : '0;
    assign mem_op_out = mem_op_r;
    assign wnum_out   = wnum_r;
    assign wen_out    = commit_ok && wen_r;
    assign exc_code   = code;
    assign pc_out     = pc_r;

endmodule

// File: logic/exe_top.sv
`timescale 1ns/1ps

module exe_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                id_valid,
    output logic                allowin,
    input  exe_pkg::alu_op_t    alu_op,
    input  exe_pkg::word_t      src_a,
    input  exe_pkg::word_t      src_b,
    input  exe_pkg::mem_op_t    mem_op,
    input  exe_pkg::word_t      store_data,
    input  exe_pkg::rnum_t      wnum,
    input  logic                wen,
    input  exe_pkg::word_t      pc,
    input  logic                mem_allowin,
    output logic                out_valid,
    output exe_pkg::word_t      alu_res,
    output exe_pkg::word_t      dm_addr,
    output exe_pkg::word_t      dm_data,
    output exe_pkg::be_t        dm_we,
    output exe_pkg::mem_op_t    mem_op_out,
    output exe_pkg::rnum_t      wnum_out,
    output logic                wen_out,
    output exe_pkg::exc_code_t  exc_code,
    output exe_pkg::word_t      pc_out
);

    store_if st_if ();      // stage to formatter, combinational

    exe_stage u_exe_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .allowin     (allowin),
        .alu_op      (alu_op),
        .src_a       (src_a),
        .src_b       (src_b),
        .mem_op      (mem_op),
        .store_data  (store_data),
        .wnum        (wnum),
        .wen         (wen),
        .pc          (pc),
        .mem_allowin (mem_allowin),
        .out_valid   (out_valid),
        .alu_res     (alu_res),
        .dm_addr     (dm_addr),
        .dm_data     (dm_data),
        .dm_we       (dm_we),
        .mem_op_out  (mem_op_out),
        .wnum_out    (wnum_out),
        .wen_out     (wen_out),
        .exc_code    (exc_code),
        .pc_out      (pc_out),
        .st          (st_if.stage),
        .fmt         (st_if.formatter)
    );

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

// File: tb/tb_exe.sv
`timescale 1ns/1ps

module tb_exe;

    typedef struct packed {
        exe_pkg::word_t     res;
        exe_pkg::word_t     data;
        exe_pkg::be_t       we;
        exe_pkg::mem_op_t   mop;
        exe_pkg::rnum_t     wnum;
        logic               wen;
        exe_pkg::exc_code_t exc;
        exe_pkg::word_t     pc;
    } expect_t;

    logic               clk;
    logic               rst_n;
    logic               id_valid;
    logic               allowin;
    exe_pkg::alu_op_t   alu_op;
    exe_pkg::word_t     src_a;
    exe_pkg::word_t     src_b;
    exe_pkg::mem_op_t   mem_op;
    exe_pkg::word_t     store_data;
    exe_pkg::rnum_t     wnum;
    logic               wen;
    exe_pkg::word_t     pc;
    logic               mem_allowin;
    logic               out_valid;
    exe_pkg::word_t     alu_res;
    exe_pkg::word_t     dm_addr;
    exe_pkg::word_t     dm_data;
    exe_pkg::be_t       dm_we;
    exe_pkg::mem_op_t   mem_op_out;
    exe_pkg::rnum_t     wnum_out;
    logic               wen_out;
    exe_pkg::exc_code_t exc_code;
    exe_pkg::word_t     pc_out;

    integer             seed;
    int                 drv_errors;
    int                 cmp_errors = 0;
    int                 sent;
    int                 checked = 0;
    logic               stall_on;
    logic               abort;
    exe_pkg::word_t     next_pc;
    expect_t            exp_q[$];
    expect_t            cur;
    logic               exp_full;       // an accepted item is still in the stage
    logic               exp_allowin;
    logic               hold_prev = 1'b0;
    logic [146:0]       held_snap;
    logic [146:0]       out_snap;

    assign out_snap = {alu_res, dm_addr, dm_data, dm_we, mem_op_out, wnum_out,
                       wen_out, exc_code, pc_out};

    clk_gen u_clk (
        .clk (clk)
    );

    exe_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .allowin     (allowin),
        .alu_op      (alu_op),
        .src_a       (src_a),
        .src_b       (src_b),
        .mem_op      (mem_op),
        .store_data  (store_data),
        .wnum        (wnum),
        .wen         (wen),
        .pc          (pc),
        .mem_allowin (mem_allowin),
        .out_valid   (out_valid),
        .alu_res     (alu_res),
        .dm_addr     (dm_addr),
        .dm_data     (dm_data),
        .dm_we       (dm_we),
        .mem_op_out  (mem_op_out),
        .wnum_out    (wnum_out),
        .wen_out     (wen_out),
        .exc_code    (exc_code),
        .pc_out      (pc_out)
    );

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic expect_t ref_exe(exe_pkg::alu_op_t op, exe_pkg::word_t a,
            exe_pkg::word_t b, exe_pkg::mem_op_t mop, exe_pkg::word_t sd,
            exe_pkg::rnum_t wn, logic w, exe_pkg::word_t pc_in);
        expect_t     e;
        logic [32:0] wide;     // sign-extended sum or difference
        logic        ov;
        int          kk;
        e  = '0;
        ov = 1'b0;
        case (op)
            exe_pkg::alu_add, exe_pkg::alu_addu: begin
                wide  = {a[31], a} + {b[31], b};
                e.res = wide[31:0];
                ov    = (op == exe_pkg::alu_add) && (wide[32] != wide[31]);
            end
            exe_pkg::alu_sub, exe_pkg::alu_subu: begin
                wide  = {a[31], a} - {b[31], b};
                e.res = wide[31:0];
                ov    = (op == exe_pkg::alu_sub) && (wide[32] != wide[31]);
            end
            exe_pkg::alu_and:  e.res = a & b;
            exe_pkg::alu_or:   e.res = a | b;
            exe_pkg::alu_xor:  e.res = a ^ b;
            exe_pkg::alu_nor:  e.res = ~(a | b);
            exe_pkg::alu_slt:  e.res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::alu_sltu: e.res = (a < b) ? 32'd1 : 32'd0;
            exe_pkg::alu_sll:  e.res = b << a[4:0];
            exe_pkg::alu_srl:  e.res = b >> a[4:0];
            exe_pkg::alu_sra:  e.res = $signed(b) >>> a[4:0];
            exe_pkg::alu_lui:  e.res = {b[15:0], 16'h0000};
            default:           e.res = '0;
        endcase
        kk = {30'b0, e.res[1:0]};   // byte offset
        if (ov) begin
            e.exc = exe_pkg::exc_ov;
        end else if (((mop == exe_pkg::mem_lh || mop == exe_pkg::mem_lhu) && e.res[0]) ||
                     (mop == exe_pkg::mem_lw && kk != 0)) begin
            e.exc = exe_pkg::exc_adel;
        end else if ((mop == exe_pkg::mem_sh && e.res[0]) ||
                     (mop == exe_pkg::mem_sw && kk != 0)) begin
            e.exc = exe_pkg::exc_ades;
        end
        case (mop)
            exe_pkg::mem_sb:  e.data = {4{sd[7:0]}};
            exe_pkg::mem_sh:  e.data = {2{sd[15:0]}};
            exe_pkg::mem_swl: e.data = sd >> (8 * (3 - kk));
            exe_pkg::mem_swr: e.data = sd << (8 * kk);
            default:          e.data = sd;
        endcase
        for (int i = 0; i < 4; i++) begin
            case (mop)
                exe_pkg::mem_sb:  e.we[i] = (i == kk);
                exe_pkg::mem_sh:  e.we[i] = ((i / 2) == (kk / 2));
                exe_pkg::mem_sw:  e.we[i] = 1'b1;
                exe_pkg::mem_swl: e.we[i] = (i <= kk);   // lanes 0..k
                exe_pkg::mem_swr: e.we[i] = (i >= kk);   // lanes k..3
                default:          e.we[i] = 1'b0;
            endcase
        end
        if (e.exc != exe_pkg::exc_none) begin
            e.we = '0;
        end
        e.wen  = w && (e.exc == exe_pkg::exc_none);
        e.mop  = mop;
        e.wnum = wn;
        e.pc   = pc_in;
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // driver tasks entered on a rising edge
    // ------------------------------------------------------------------------

    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        r = $random(seed);
        mem_allowin <= stall_on ? (r[0] | r[1]) : 1'b1;   // stall about 1 in 4
    endtask

    task automatic send_instr(exe_pkg::alu_op_t op, exe_pkg::word_t a, exe_pkg::word_t b,
            exe_pkg::mem_op_t mop, exe_pkg::word_t sd, exe_pkg::rnum_t wn, logic w);
        int   n;
        logic acc;
        if (!abort) begin
            alu_op     <= op;
            src_a      <= a;
            src_b      <= b;
            mem_op     <= mop;
            store_data <= sd;
            wnum       <= wn;
            wen        <= w;
            pc         <= next_pc;
            id_valid   <= 1'b1;
            n   = 0;
            acc = 1'b0;
            while (!acc && n < 50) begin
                @(negedge clk);
                acc = allowin;      // taken at the coming edge
                tick();
                n++;
            end
            if (acc) begin
                exp_q.push_back(ref_exe(op, a, b, mop, sd, wn, w, next_pc));
                sent++;
                next_pc = next_pc + 32'd4;
            end else begin
                $display("timeout: instruction at pc %h was never accepted", next_pc);
                drv_errors++;
                abort = 1'b1;
            end
        end
    endtask

    task automatic drain_stage();
        int   n;
        logic busy;
        id_valid <= 1'b0;
        n    = 0;
        busy = !abort;
        while (busy && n < 100) begin
            @(negedge clk);
            busy = out_valid;
            tick();
            n++;
        end
        if (busy) begin
            $display("timeout: stage still holds an instruction after 100 cycles");
            drv_errors++;
            abort = 1'b1;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        seed        = 32'h5e16_f340;
        drv_errors  = 0;
        sent        = 0;
        stall_on    = 1'b0;
        abort       = 1'b0;
        next_pc     = 32'hbfc0_0000;
        rst_n       = 1'b0;
        id_valid    = 1'b0;
        alu_op      = exe_pkg::alu_add;
        src_a       = '0;
        src_b       = '0;
        mem_op      = exe_pkg::mem_none;
        store_data  = '0;
        wnum        = '0;
        wen         = 1'b0;
        pc          = '0;
        mem_allowin = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("mismatch at %0t: out_valid expected 0 got %b", $time, out_valid);
            drv_errors++;
        end
        if (allowin !== 1'b1) begin
            $display("mismatch at %0t: allowin expected 1 got %b", $time, allowin);
            drv_errors++;
        end
        tick();

        // every alu op with random operands, then overflow corners
        for (int i = 0; i < 14; i++) begin
            for (int j = 0; j < 4; j++) begin
                r  = $random(seed);
                r2 = $random(seed);
                send_instr(exe_pkg::alu_op_t'(i[3:0]), r, r2, exe_pkg::mem_none, '0,
                           r2[12:8], 1'b1);
            end
        end
        send_instr(exe_pkg::alu_add,  32'h7fff_ffff, 32'h1, exe_pkg::mem_none, '0, 5'd3, 1'b1);
        send_instr(exe_pkg::alu_addu, 32'h7fff_ffff, 32'h1, exe_pkg::mem_none, '0, 5'd4, 1'b1);
        send_instr(exe_pkg::alu_sub,  32'h8000_0000, 32'h1, exe_pkg::mem_none, '0, 5'd5, 1'b1);
        send_instr(exe_pkg::alu_subu, 32'h8000_0000, 32'h1, exe_pkg::mem_none, '0, 5'd6, 1'b1);
        send_instr(exe_pkg::alu_add,  32'h8000_0000, 32'h8000_0000, exe_pkg::mem_none, '0,
                   5'd7, 1'b1);

        // loads 1..7 and stores 8..12 at every byte offset
        for (int m = 1; m <= 12; m++) begin
            for (int k = 0; k < 4; k++) begin
                r  = $random(seed);
                r2 = $random(seed);
                send_instr(exe_pkg::alu_addu, {r[31:2], 2'b00}, k,
                           exe_pkg::mem_op_t'(m[3:0]), r2, r[6:2], m < 8);
            end
        end

        // random mix under back-pressure and bubbles
        stall_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            if (r[14]) begin
                id_valid <= 1'b0;
                tick();
            end
            send_instr(exe_pkg::alu_op_t'(r[3:0] % 4'd14), r2, r3,
                       exe_pkg::mem_op_t'(r[7:4] % 4'd13), r3, r[12:8], r[13]);
        end
        drain_stage();

        if (sent != checked) begin
            $display("error: %0d instructions accepted but %0d retired", sent, checked);
            drv_errors++;
        end
        $display("tb_exe: %0d sent, %0d checked, %0d errors", sent, checked,
                 drv_errors + cmp_errors);
        if (drv_errors + cmp_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // compare at mid-cycle
    // ------------------------------------------------------------------------

    task automatic report_mismatch(string name, exe_pkg::word_t exp_v, exe_pkg::word_t act_v);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
        cmp_errors++;
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            exp_full    = (exp_q.size() != 0);
            exp_allowin = !exp_full || mem_allowin;
            if (!out_valid && (wen_out !== 1'b0 || dm_we !== '0)) begin
                $display("error at %0t: wen_out or dm_we active with out_valid low", $time);
                cmp_errors++;
            end
            if (out_valid !== exp_full) begin
                report_mismatch("out_valid", 32'(exp_full), 32'(out_valid));
            end
            if (allowin !== exp_allowin) begin
                report_mismatch("allowin", 32'(exp_allowin), 32'(allowin));
            end
            if (hold_prev && (out_valid !== 1'b1 || out_snap !== held_snap)) begin
                $display("mismatch at %0t: held outputs expected %h got %h", $time,
                         held_snap, out_snap);
                cmp_errors++;
            end
            if (out_valid && mem_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("error at %0t: out_valid high with nothing accepted", $time);
                    cmp_errors++;
                end else begin
                    cur = exp_q.pop_front();
                    checked++;
                    if (alu_res !== cur.res) report_mismatch("alu_res", cur.res, alu_res);
                    if (dm_addr !== cur.res) report_mismatch("dm_addr", cur.res, dm_addr);
                    if (|cur.we && dm_data !== cur.data) begin
                        report_mismatch("dm_data", cur.data, dm_data);
                    end
                    if (dm_we !== cur.we) report_mismatch("dm_we", 32'(cur.we), 32'(dm_we));
                    if (mem_op_out !== cur.mop) begin
                        report_mismatch("mem_op_out", 32'(cur.mop), 32'(mem_op_out));
                    end
                    if (wnum_out !== cur.wnum) begin
                        report_mismatch("wnum_out", 32'(cur.wnum), 32'(wnum_out));
                    end
                    if (wen_out !== cur.wen) begin
                        report_mismatch("wen_out", 32'(cur.wen), 32'(wen_out));
                    end
                    if (exc_code !== cur.exc) begin
                        report_mismatch("exc_code", 32'(cur.exc), 32'(exc_code));
                    end
                    if (pc_out !== cur.pc) report_mismatch("pc_out", cur.pc, pc_out);
                end
            end
            hold_prev = out_valid && !mem_allowin;
            held_snap = out_snap;
        end
    end

endmodule

// File: exe_unit.f
+incdir+common
common/exe_pkg.sv
common/store_if.sv
exe/alu.sv
exe/store_align.sv
exe/addr_exc.sv
exe/exe_stage.sv
logic/exe_top.sv
tb/clk_gen.sv
tb/tb_exe.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_exe \
    -f exe_unit.f -o sim_exe

out="$(./obj_dir/sim_exe)"
echo "$out"

if grep -qx "NO ERRORS" <<< "$out"; then
    exit 0
fi
exit 1
